// File: flist.f
source/bridge_pkg.sv
source/cmd_deserializer.sv
source/cmd_buffer.sv
source/cmd_executor.sv
source/reply_serializer.sv
source/cy_cmd_bridge.sv
tests/tb_cy_cmd_bridge.sv

// File: Makefile
# Verilator flow for the host command bridge
TOP = tb_cy_cmd_bridge

.PHONY: all run lint clean

all: run

run:
	verilator --binary --timing --assert --timescale 1ns/1ns -f flist.f \
	  --top-module $(TOP) -Mdir obj_dir -o sim
	./obj_dir/sim | tee sim.log
	grep -q "Verification passed" sim.log

lint:
	verilator --lint-only -Wall --timing --timescale 1ns/1ns -f flist.f \
	  --top-module cy_cmd_bridge

clean:
	rm -rf obj_dir sim.log

// File: tests/host_link_input.txt
# cmd dat flag reply0 reply1, all hex
# flag 0 no reply, 1 reply expected, 2 eighteen strobes with cy_int1 low
30 5a 1 12 5a
30 a5 1 12 a5
03 00 1 00 00
01 02 0 00 00
02 c3 0 00 00
01 05 0 00 00
02 7e 0 00 00
03 02 1 c3 00
03 05 1 7e 00
02 99 0 00 00
03 05 1 99 00
03 0d 1 99 00
55 21 2 00 00
00 00 2 00 00
03 02 1 c3 00
03 07 1 00 00
30 ff 1 12 ff

// File: tests/tb_cy_cmd_bridge.sv
`timescale 1ns/1ns

module tb_cy_cmd_bridge;

  localparam int CLK_HALF      = 50;          // 100 ns period
  localparam int BUSY_WAIT     = 32;          // clocks allowed for busy to drop
  localparam int CLKS_PER_LINE = 40 * 8 + 8;  // strobe budget plus idle gap

  logic       sys_clk = 1'b0;
  logic       sys_rst_n;
  logic       cy_wu2;
  logic       cy_int0;
  logic       cy_int1;
  logic [7:0] cy_cmd;
  logic [7:0] cy_dat;
  logic [7:0] cy_snd_data0;
  logic [7:0] cy_snd_data1;
  logic       busy;

  // one entry per data file line
  logic [7:0] t_cmd  [$];
  logic [7:0] t_dat  [$];
  logic [7:0] t_flag [$];  // 0 none, 1 reply, 2 silent line
  logic [7:0] t_r0   [$];
  logic [7:0] t_r1   [$];

  int          errors      = 0;
  int          checks      = 0;
  int          cycle_cnt   = 0;
  int          cycle_limit = 0;  // set once the file is read
  logic [31:0] lcg_state   = 32'hcd40_f8be;

  cy_cmd_bridge #(
    .DATA_DEPTH (8)
  ) DUT (
    .sys_clk      (sys_clk),
    .sys_rst_n    (sys_rst_n),
    .cy_wu2       (cy_wu2),
    .cy_int0      (cy_int0),
    .cy_int1      (cy_int1),
    .cy_cmd       (cy_cmd),
    .cy_dat       (cy_dat),
    .cy_snd_data0 (cy_snd_data0),
    .cy_snd_data1 (cy_snd_data1),
    .busy         (busy)
  );

  always #CLK_HALF sys_clk = ~sys_clk;

  // run length guard
  always @(posedge sys_clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_limit != 0 && cycle_cnt >= cycle_limit) begin
      $display("timeout, run stopped after %0d clocks", cycle_cnt);
      $display("Verification failed");
      $finish;
    end
  end

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // wire order of a reply, bit i is the i-th strobe
  function automatic logic [17:0] reply_bits(input logic [7:0] b0, input logic [7:0] b1);
    return {1'b0, b1, b0, 1'b1};
  endfunction

  task automatic compare_value(input string sig, input logic [17:0] got,
                               input logic [17:0] exp);
    checks++;
    assert (got == exp) else begin
      $display("FAILED t=%0t %s got %0h expected %0h", $time, sig, got, exp);
      errors++;
    end
  endtask

  task automatic read_vectors();
    int         fd;
    int         code;
    int         n;
    string      line;
    logic [7:0] c;
    logic [7:0] d;
    logic [7:0] f;
    logic [7:0] r0;
    logic [7:0] r1;
    fd = $fopen("tests/host_link_input.txt", "r");
    if (fd == 0) begin
      $display("cannot open tests/host_link_input.txt, no tests run");
      errors++;
    end else begin
      while (!$feof(fd)) begin
        code = $fgets(line, fd);
        if (code > 0 && line.getc(0) != "#") begin  // skip column notes
          n = $sscanf(line, "%h %h %h %h %h", c, d, f, r0, r1);
          if (n == 5) begin
            t_cmd.push_back(c);
            t_dat.push_back(d);
            t_flag.push_back(f);
            t_r0.push_back(r0);
            t_r1.push_back(r1);
          end
        end
      end
      $fclose(fd);
      if (t_cmd.size() == 0) begin
        $display("data file holds no test lines");
        errors++;
      end
    end
  endtask

  // poll busy at negedges, give up after BUSY_WAIT clocks
  task automatic wait_busy_low(output logic ok);
    int n;
    ok = 1'b0;
    n  = 0;
    while (!ok && n < BUSY_WAIT) begin
      @(negedge sys_clk);
      if (!busy) ok = 1'b1;
      n++;
    end
  endtask

  // one host strobe, entered and left on a rising edge
  task automatic strobe_bit(input logic b, output logic rx);
    cy_wu2  <= 1'b0;
    cy_int0 <= b;  // data set up while strobe low
    repeat (4) @(posedge sys_clk);
    cy_wu2 <= 1'b1;
    repeat (4) @(posedge sys_clk);
    @(negedge sys_clk);
    rx = cy_int1;  // bridge moved it 4 clocks after the edge
    @(posedge sys_clk);
  endtask

  task automatic send_frame(input logic [7:0] c, input logic [7:0] d);
    logic [16:0] bits;
    logic        unused_rx;
    bits = {d, c, 1'b1};  // start bit, then both bytes LSB first
    @(posedge sys_clk);
    for (int i = 0; i < 17; i++) begin
      strobe_bit(bits[i], unused_rx);
    end
  endtask

  // 18 strobes with cy_int0 low, collecting cy_int1
  task automatic clock_reply(output logic [17:0] got);
    logic rx;
    got = '0;
    @(posedge sys_clk);
    for (int i = 0; i < 18; i++) begin
      strobe_bit(1'b0, rx);
      got[i] = rx;
    end
  endtask

  initial begin : main_seq
    logic        ok;
    logic [17:0] got;
    int          gap;
    int          err_before;
    sys_rst_n = 1'b0;
    cy_wu2    = 1'b0;
    cy_int0   = 1'b0;
    read_vectors();
    cycle_limit = t_cmd.size() * CLKS_PER_LINE + 100;
    repeat (3) @(posedge sys_clk);
    sys_rst_n <= 1'b1;
    @(negedge sys_clk);
    compare_value("cy_int1", 18'(cy_int1), 18'h0);
    compare_value("busy", 18'(busy), 18'h0);
    compare_value("cy_cmd", 18'(cy_cmd), 18'h0);
    compare_value("cy_dat", 18'(cy_dat), 18'h0);
    $display("test 0: reset values %s", (errors == 0) ? "ok" : "mismatch");
    for (int i = 0; i < t_cmd.size(); i++) begin
      err_before = errors;
      wait_busy_low(ok);  // previous command must be finished
      assert (ok) else begin
        $display("busy still high before test %0d, previous command stuck", i + 1);
        errors++;
      end
      gap = int'(lcg_next() >> 30);  // 0..3 idle clocks
      repeat (gap) @(posedge sys_clk);
      send_frame(t_cmd[i], t_dat[i]);
      @(negedge sys_clk);
      compare_value("busy", 18'(busy), 18'h1);  // frame held, command running
      wait_busy_low(ok);
      assert (ok) else begin
        $display("busy did not drop within %0d clocks of the frame", BUSY_WAIT);
        errors++;
      end
      compare_value("cy_cmd", 18'(cy_cmd), 18'(t_cmd[i]));
      compare_value("cy_dat", 18'(cy_dat), 18'(t_dat[i]));
      if (t_flag[i] == 8'h01) begin
        clock_reply(got);
        compare_value("cy_int1 bits", got, reply_bits(t_r0[i], t_r1[i]));
        compare_value("cy_snd_data0", 18'(cy_snd_data0), 18'(t_r0[i]));
        compare_value("cy_snd_data1", 18'(cy_snd_data1), 18'(t_r1[i]));
      end else if (t_flag[i] == 8'h02) begin
        clock_reply(got);
        compare_value("cy_int1 bits", got, 18'h0);  // line must stay quiet
      end
      $display("test %0d: cmd %02h dat %02h %s", i + 1, t_cmd[i], t_dat[i],
               (errors == err_before) ? "ok" : "mismatch");
    end
    $display("%0d tests, %0d checks, %0d errors", t_cmd.size() + 1, checks, errors);
    if (errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

// File: source/cy_cmd_bridge.sv
`timescale 1ns/1ns

module cy_cmd_bridge import bridge_pkg::*; #(
  parameter int DATA_DEPTH = 8  // byte store size
) (
  input  logic              sys_clk,
  input  logic              sys_rst_n,
  input  logic              cy_wu2,        // host strobe
  input  logic              cy_int0,       // host to bridge
  output logic              cy_int1,       // bridge to host
  output logic [BYTE_W-1:0] cy_cmd,        // last received command
  output logic [BYTE_W-1:0] cy_dat,        // last received data
  output logic [BYTE_W-1:0] cy_snd_data0,  // reply byte 0
  output logic [BYTE_W-1:0] cy_snd_data1,  // reply byte 1
  output logic              busy
);

  logic              bit_strobe;
  logic              frame_valid;
  logic [BYTE_W-1:0] frame_cmd;
  logic [BYTE_W-1:0] frame_dat;
  logic              cmd_pending;
  logic              cmd_done;
  logic              reply_req;
  logic              reply_ack;
  reply_word_u       reply_word;

  cmd_deserializer u_deser (
    .sys_clk     (sys_clk),
    .sys_rst_n   (sys_rst_n),
    .cy_wu2      (cy_wu2),
    .cy_int0     (cy_int0),
    .bit_strobe  (bit_strobe),
    .frame_valid (frame_valid),
    .frame_cmd   (frame_cmd),
    .frame_dat   (frame_dat)
  );

  // held bytes go straight to the pins
  cmd_buffer u_buffer (
    .sys_clk     (sys_clk),
    .sys_rst_n   (sys_rst_n),
    .frame_valid (frame_valid),
    .frame_cmd   (frame_cmd),
    .frame_dat   (frame_dat),
    .cmd_done    (cmd_done),
    .cmd_pending (cmd_pending),
    .held_cmd    (cy_cmd),
    .held_dat    (cy_dat),
    .busy        (busy)
  );

  cmd_executor #(
    .DATA_DEPTH (DATA_DEPTH)
  ) u_exec (
    .sys_clk     (sys_clk),
    .sys_rst_n   (sys_rst_n),
    .cmd_pending (cmd_pending),
    .held_cmd    (cy_cmd),
    .held_dat    (cy_dat),
    .reply_ack   (reply_ack),
    .cmd_take    (),
    .cmd_done    (cmd_done),
    .reply_req   (reply_req),
    .reply_word  (reply_word)
  );

  reply_serializer u_ser (
    .sys_clk    (sys_clk),
    .sys_rst_n  (sys_rst_n),
    .bit_strobe (bit_strobe),
    .reply_req  (reply_req),
    .reply_word (reply_word),
    .reply_ack  (reply_ack),
    .cy_int1    (cy_int1)
  );

  // executor reply bytes, byte view of the union
  assign cy_snd_data0 = reply_word.bytes.byte0;
  assign cy_snd_data1 = reply_word.bytes.byte1;

endmodule

// File: source/reply_serializer.sv
`timescale 1ns/1ns

module reply_serializer import bridge_pkg::*; (
  input  logic        sys_clk,
  input  logic        sys_rst_n,
  input  logic        bit_strobe,  // synchronized host strobe
  input  logic        reply_req,
  input  reply_word_u reply_word,
  output logic        reply_ack,   // one pulse after the trailing 0
  output logic        cy_int1      // bridge to host bit
);

  // strobes in a reply: start, payload, trailing 0
  localparam int STEP_W    = $clog2(REPLY_WORD_W + 2);
  localparam int LAST_STEP = REPLY_WORD_W + 1;

  logic                    sending;
  logic                    wait_low;  // old request still up after ack
  logic [STEP_W-1:0]       step;      // strobes already used
  logic [REPLY_WORD_W-1:0] shift_q;   // payload, bit 0 goes next

  always_ff @(posedge sys_clk or negedge sys_rst_n) begin
    if (!sys_rst_n) begin
      sending   <= 1'b0;
      wait_low  <= 1'b0;
      step      <= '0;
      reply_ack <= 1'b0;
      cy_int1   <= 1'b0;
    end else begin
      reply_ack <= 1'b0;
      if (!reply_req) begin
        wait_low <= 1'b0;  // executor saw the ack
      end
      if (bit_strobe) begin
        if (!sending) begin
          if (reply_req && !wait_low) begin
            sending <= 1'b1;
            step    <= STEP_W'(1);
            cy_int1 <= 1'b1;  // start bit
          end
        end else if (step == STEP_W'(LAST_STEP)) begin
          cy_int1   <= 1'b0;  // trailing 0
          sending   <= 1'b0;
          step      <= '0;
          reply_ack <= 1'b1;
          wait_low  <= 1'b1;
        end else begin
          cy_int1 <= shift_q[0];
          step    <= step + 1'b1;
        end
      end
    end
  end

  // payload path, loaded at the start bit
  always_ff @(posedge sys_clk) begin
    if (bit_strobe) begin
      if (!sending) begin
        shift_q <= reply_word.raw;  // byte0 lands in the low bits
      end else begin
        shift_q <= {1'b0, shift_q[REPLY_WORD_W-1:1]};
      end
    end
  end

endmodule

// File: source/cmd_executor.sv
`timescale 1ns/1ns

module cmd_executor import bridge_pkg::*; #(
  parameter int DATA_DEPTH = 8  // byte store entries, power of two
) (
  input  logic              sys_clk,
  input  logic              sys_rst_n,
  input  logic              cmd_pending,
  input  logic [BYTE_W-1:0] held_cmd,
  input  logic [BYTE_W-1:0] held_dat,
  input  logic              reply_ack,  // serializer sent the trailing 0
  output logic              cmd_take,   // start of a command
  output logic              cmd_done,   // end of a command
  output logic              reply_req,  // level, held until reply_ack
  output reply_word_u       reply_word
);

  localparam int ADDR_W = (DATA_DEPTH > 1) ? $clog2(DATA_DEPTH) : 1;

  logic [BYTE_W-1:0] store [DATA_DEPTH];
  logic [ADDR_W-1:0] store_addr;  // set by OP_SET_ADDR
  logic [ADDR_W-1:0] rd_idx;      // READ indexes by the data byte
  logic              in_cmd;      // current command already taken
  logic              exec_en;

  // take once per buffered frame
  assign cmd_take = cmd_pending && !in_cmd;
  // keep working until done goes out, which also covers a reply stall
  assign exec_en  = cmd_pending && !cmd_done;
  assign rd_idx   = held_dat[ADDR_W-1:0];  // low bits only

  always_ff @(posedge sys_clk or negedge sys_rst_n) begin
    if (!sys_rst_n) begin
      in_cmd <= 1'b0;
    end else if (cmd_done) begin
      in_cmd <= 1'b0;
    end else if (cmd_take) begin
      in_cmd <= 1'b1;
    end
  end

  always_ff @(posedge sys_clk or negedge sys_rst_n) begin
    if (!sys_rst_n) begin
      cmd_done   <= 1'b0;
      reply_req  <= 1'b0;
      reply_word <= '0;
      store_addr <= '0;
      for (int i = 0; i < DATA_DEPTH; i++) begin
        store[i] <= '0;  // unwritten entries read 0
      end
    end else begin
      cmd_done <= 1'b0;  // single cycle pulse
      if (reply_ack) begin
        reply_req <= 1'b0;
      end
      if (exec_en) begin
        case (held_cmd)
          OP_SET_ADDR: begin
            store_addr <= held_dat[ADDR_W-1:0];
            cmd_done   <= 1'b1;
          end
          OP_WRITE: begin
            store[store_addr] <= held_dat;
            cmd_done          <= 1'b1;
          end
          OP_READ: begin
            // wait for the link to be free
            if (!reply_req) begin
              reply_word.bytes.byte0 <= store[rd_idx];
              reply_word.bytes.byte1 <= '0;
              reply_req              <= 1'b1;
              cmd_done               <= 1'b1;
            end
          end
          OP_ECHO: begin
            if (!reply_req) begin
              reply_word.bytes.byte0 <= ACK_TAG;
              reply_word.bytes.byte1 <= held_dat;  // echo the data byte
              reply_req              <= 1'b1;
              cmd_done               <= 1'b1;
            end
          end
          default: begin
            cmd_done <= 1'b1;  // OP_IDLE or unknown, no effect
          end
        endcase
      end
    end
  end

  // serializer only acks a reply that is outstanding
  a_ack_with_req : assert property (
    @(posedge sys_clk) disable iff (!sys_rst_n)
    reply_ack |-> reply_req
  ) else $error("reply_ack with no reply outstanding");

endmodule

// File: source/cmd_buffer.sv
`timescale 1ns/1ns

module cmd_buffer import bridge_pkg::*; (
  input  logic              sys_clk,
  input  logic              sys_rst_n,
  input  logic              frame_valid,  // from deserializer
  input  logic [BYTE_W-1:0] frame_cmd,
  input  logic [BYTE_W-1:0] frame_dat,
  input  logic              cmd_done,     // executor finished
  output logic              cmd_pending,  // frame waiting or running
  output logic [BYTE_W-1:0] held_cmd,     // also the cy_cmd pins
  output logic [BYTE_W-1:0] held_dat,     // also the cy_dat pins
  output logic              busy
);

  logic full;  // one entry deep

  always_ff @(posedge sys_clk or negedge sys_rst_n) begin
    if (!sys_rst_n) begin
      full     <= 1'b0;
      held_cmd <= '0;  // pins read 0 after reset
      held_dat <= '0;
    end else begin
      if (cmd_done) begin
        full <= 1'b0;  // bytes stay visible on the pins
      end else if (frame_valid && !full) begin
        full     <= 1'b1;
        held_cmd <= frame_cmd;
        held_dat <= frame_dat;
      end
      // a frame while full is dropped here
    end
  end

  assign cmd_pending = full;
  assign busy        = full;  // host waits on this between frames

  // host must honour busy
  a_no_overrun : assert property (
    @(posedge sys_clk) disable iff (!sys_rst_n)
    frame_valid |-> !full
  ) else $error("frame arrived while the command buffer was full");

  // executor only completes what it was given
  a_done_when_full : assert property (
    @(posedge sys_clk) disable iff (!sys_rst_n)
    cmd_done |-> full
  ) else $error("cmd_done with no pending command");

endmodule

// File: source/cmd_deserializer.sv
`timescale 1ns/1ns

module cmd_deserializer import bridge_pkg::*; (
  input  logic              sys_clk,
  input  logic              sys_rst_n,
  input  logic              cy_wu2,       // host bit strobe, async
  input  logic              cy_int0,      // host to bridge data, async
  output logic              bit_strobe,   // one pulse per wake rising edge
  output logic              frame_valid,  // full frame this cycle
  output logic [BYTE_W-1:0] frame_cmd,
  output logic [BYTE_W-1:0] frame_dat
);

  localparam int CNT_W = $clog2(FRAME_BITS + 1);

  // wake line sync and edge detect
  logic wu2_s1;
  logic wu2_s2;
  logic wu2_q;   // delayed copy for the edge
  // data line gets one more stage so it lines up with bit_strobe
  logic int0_s1;
  logic int0_s2;
  logic int0_s3;

  logic [CNT_W-1:0]      bit_cnt;   // 0 = hunting for start bit
  logic [FRAME_BITS-1:1] shift_q;   // last 15 payload bits
  logic [FRAME_BITS-1:0] shift_nxt; // shift_q with the current bit in
  logic                  last_bit;

  always_ff @(posedge sys_clk or negedge sys_rst_n) begin
    if (!sys_rst_n) begin
      wu2_s1     <= 1'b0;
      wu2_s2     <= 1'b0;
      wu2_q      <= 1'b0;
      int0_s1    <= 1'b0;
      int0_s2    <= 1'b0;
      int0_s3    <= 1'b0;
      bit_strobe <= 1'b0;
    end else begin
      wu2_s1     <= cy_wu2;
      wu2_s2     <= wu2_s1;
      wu2_q      <= wu2_s2;
      int0_s1    <= cy_int0;
      int0_s2    <= int0_s1;
      int0_s3    <= int0_s2;
      bit_strobe <= wu2_s2 & ~wu2_q;  // rising edge, 3 clocks after the pin
    end
  end

  // LSB first, so new bits enter at the top and move down
  assign shift_nxt = {int0_s3, shift_q};
  assign last_bit  = (bit_cnt == CNT_W'(FRAME_BITS));

  always_ff @(posedge sys_clk or negedge sys_rst_n) begin
    if (!sys_rst_n) begin
      bit_cnt <= '0;
    end else if (bit_strobe) begin
      if (bit_cnt == '0) begin
        if (int0_s3) begin
          bit_cnt <= CNT_W'(1);  // start bit seen
        end
      end else if (last_bit) begin
        bit_cnt <= '0;  // frame complete, hunt again
      end else begin
        bit_cnt <= bit_cnt + 1'b1;
      end
    end
  end

  // payload shifter
  always_ff @(posedge sys_clk) begin
    if (bit_strobe && bit_cnt != '0) begin
      shift_q <= shift_nxt[FRAME_BITS-1:1];
    end
  end

  // 17th strobe of the frame
  assign frame_valid = bit_strobe & last_bit;
  assign frame_cmd   = shift_nxt[BYTE_W-1:0];           // first 8 payload bits
  assign frame_dat   = shift_nxt[FRAME_BITS-1:BYTE_W];  // last 8

  // host data must settle at least a clock ahead of the wake edge
  a_data_setup : assert property (
    @(posedge sys_clk) disable iff (!sys_rst_n)
    bit_strobe |-> $stable(int0_s3)
  ) else $error("host data changed at the wake edge");

endmodule

// File: source/bridge_pkg.sv
package bridge_pkg;

  // field widths
  localparam int BYTE_W       = 8;   // command, data and reply bytes
  localparam int FRAME_BITS   = 16;  // payload bits after the start bit
  localparam int REPLY_WORD_W = 16;  // reply payload, two bytes

  // host opcodes
  localparam logic [BYTE_W-1:0] OP_IDLE     = 8'h00;  // nothing to do
  localparam logic [BYTE_W-1:0] OP_SET_ADDR = 8'h01;  // store address <= data
  localparam logic [BYTE_W-1:0] OP_WRITE    = 8'h02;  // store[addr] <= data
  localparam logic [BYTE_W-1:0] OP_READ     = 8'h03;  // reply store[data], 0
  localparam logic [BYTE_W-1:0] OP_ECHO     = 8'h30;  // link test

  // first reply byte of a link echo
  localparam logic [BYTE_W-1:0] ACK_TAG = 8'h12;

  // reply payload
  // the executor fills the two bytes and the serializer shifts the raw word.
  // byte0 sits in the low half so it leaves the link first
  typedef union packed {
    struct packed {
      logic [BYTE_W-1:0] byte1;  // second on the wire
      logic [BYTE_W-1:0] byte0;  // first on the wire
    } bytes;
    logic [REPLY_WORD_W-1:0] raw;  // LSB first shift view
  } reply_word_u;

endpackage
